// ==== logic/udp_link_pkg.sv ====
`default_nettype none

package udp_link_pkg;

    localparam int AXIS_DATA_WIDTH = 8;
    localparam int AXIS_USER_WIDTH = 11;

    localparam logic [7:0] PREAMBLE_BYTE = 8'h55;
    localparam logic [7:0] SFD_BYTE      = 8'hD5;
    localparam int         PREAMBLE_LEN  = 8;

    localparam int ETH_HDR_BYTES  = 14;
    localparam int IPV4_HDR_BYTES = 20;
    localparam int UDP_HDR_BYTES  = 8;
    localparam int HEADER_BYTES   = ETH_HDR_BYTES + IPV4_HDR_BYTES + UDP_HDR_BYTES;

    localparam logic [15:0] ETHERTYPE_IPV4 = 16'h0800;
    localparam logic [7:0]  IPV4_VER_IHL   = 8'h45;
    localparam logic [7:0]  IPV4_TOS       = 8'h00;
    localparam logic [15:0] IPV4_ID        = 16'h0000;
    localparam logic [15:0] IPV4_FLAGS     = 16'h4000;
    localparam logic [7:0]  IPV4_TTL       = 8'd64;
    localparam logic [7:0]  IP_PROTO_UDP   = 8'd17;

    // Header fields in the order they appear on the wire.
    typedef struct packed {
        logic [47:0] dst_mac;
        logic [47:0] src_mac;
        logic [15:0] ethertype;
        logic [7:0]  ip_ver_ihl;
        logic [7:0]  ip_tos;
        logic [15:0] ip_total_len;
        logic [15:0] ip_id;
        logic [15:0] ip_flags_frag;
        logic [7:0]  ip_ttl;
        logic [7:0]  ip_protocol;
        logic [15:0] ip_checksum;
        logic [31:0] src_ip;
        logic [31:0] dst_ip;
        logic [15:0] src_port;
        logic [15:0] dst_port;
        logic [15:0] udp_len;
        logic [15:0] udp_checksum;
    } frame_header_t;

    // Byte HEADER_BYTES-1 of the byte view is the first byte on the wire.
    typedef union packed {
        frame_header_t                    fields;
        logic [HEADER_BYTES-1:0][7:0]     bytes;
    } frame_header_u;

    typedef struct packed {
        logic [AXIS_DATA_WIDTH-1:0] data;
        logic                       last;
        logic [AXIS_USER_WIDTH-1:0] user;
    } stream_beat_t;

endpackage

`default_nettype wire

// ==== logic/udp_frame_tx.sv ====
`timescale 1ns/1ps
`default_nettype none

module udp_frame_tx #(
    parameter logic [15:0] HEADER_CHECKSUM = 16'h65b3
) (
    input  logic                       clk_i,
    input  logic                       reset_i,

    input  logic                       s_valid_i,
    input  udp_link_pkg::stream_beat_t s_beat_i,
    output logic                       s_ready_o,

    input  logic [47:0]                fpga_mac_i,
    input  logic [31:0]                fpga_ip_i,
    input  logic [15:0]                fpga_port_i,
    input  logic [47:0]                host_mac_i,
    input  logic [31:0]                host_ip_i,
    input  logic [15:0]                host_port_i,

    output logic                       gmii_tx_en_o,
    output logic [7:0]                 gmii_txd_o
);

    import udp_link_pkg::*;

    localparam int IFG_CYCLES = 12;

    typedef logic [AXIS_USER_WIDTH-1:0] cnt_t;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_PREAMBLE,
        ST_HEADER,
        ST_PAYLOAD,
        ST_GAP
    } tx_state_e;

    tx_state_e     state_q;
    cnt_t          byte_cnt_q;
    cnt_t          len_q;
    frame_header_u hdr_q;
    frame_header_u hdr_d;

    // ~~~~~~~~~~~~~~~~~~~~
    // Header assembly from the address inputs and the offered length.
    always_comb begin
        hdr_d.fields.dst_mac       = host_mac_i;
        hdr_d.fields.src_mac       = fpga_mac_i;
        hdr_d.fields.ethertype     = ETHERTYPE_IPV4;
        hdr_d.fields.ip_ver_ihl    = IPV4_VER_IHL;
        hdr_d.fields.ip_tos        = IPV4_TOS;
        hdr_d.fields.ip_total_len  = 16'(IPV4_HDR_BYTES + UDP_HDR_BYTES) + 16'(s_beat_i.user);
        hdr_d.fields.ip_id         = IPV4_ID;
        hdr_d.fields.ip_flags_frag = IPV4_FLAGS;
        hdr_d.fields.ip_ttl        = IPV4_TTL;
        hdr_d.fields.ip_protocol   = IP_PROTO_UDP;
        hdr_d.fields.ip_checksum   = HEADER_CHECKSUM;
        hdr_d.fields.src_ip        = fpga_ip_i;
        hdr_d.fields.dst_ip        = host_ip_i;
        hdr_d.fields.src_port      = fpga_port_i;
        hdr_d.fields.dst_port      = host_port_i;
        hdr_d.fields.udp_len       = 16'(UDP_HDR_BYTES) + 16'(s_beat_i.user);
        hdr_d.fields.udp_checksum  = 16'h0000;
    end

    assign s_ready_o = (state_q == ST_PAYLOAD);

    // ~~~~~~~~~~~~~~~~~~~~
    // Frame sequencing.
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q      <= ST_IDLE;
            byte_cnt_q   <= '0;
            gmii_tx_en_o <= 1'b0;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (s_valid_i) begin
                        state_q      <= ST_PREAMBLE;
                        byte_cnt_q   <= cnt_t'(1);
                        gmii_tx_en_o <= 1'b1;
                    end
                end
                ST_PREAMBLE: begin
                    if (byte_cnt_q == cnt_t'(PREAMBLE_LEN - 1)) begin
                        state_q    <= ST_HEADER;
                        byte_cnt_q <= '0;
                    end else begin
                        byte_cnt_q <= byte_cnt_q + cnt_t'(1);
                    end
                end
                ST_HEADER: begin
                    if (byte_cnt_q == cnt_t'(HEADER_BYTES - 1)) begin
                        state_q    <= ST_PAYLOAD;
                        byte_cnt_q <= '0;
                    end else begin
                        byte_cnt_q <= byte_cnt_q + cnt_t'(1);
                    end
                end
                ST_PAYLOAD: begin
                    if (s_valid_i) begin
                        if (byte_cnt_q == len_q - cnt_t'(1)) begin
                            state_q    <= ST_GAP;
                            byte_cnt_q <= '0;
                        end else begin
                            byte_cnt_q <= byte_cnt_q + cnt_t'(1);
                        end
                    end
                end
                default: begin
                    // The first gap cycle still carries the last payload byte.
                    gmii_tx_en_o <= 1'b0;
                    if (byte_cnt_q == cnt_t'(IFG_CYCLES - 1)) begin
                        state_q    <= ST_IDLE;
                        byte_cnt_q <= '0;
                    end else begin
                        byte_cnt_q <= byte_cnt_q + cnt_t'(1);
                    end
                end
            endcase
        end
    end

    // Byte path onto GMII.
    always_ff @(posedge clk_i) begin
        case (state_q)
            ST_IDLE: begin
                gmii_txd_o <= s_valid_i ? PREAMBLE_BYTE : 8'h00;
                if (s_valid_i) begin
                    hdr_q <= hdr_d;
                    len_q <= s_beat_i.user;
                end
            end
            ST_PREAMBLE: begin
                gmii_txd_o <= (byte_cnt_q == cnt_t'(PREAMBLE_LEN - 1)) ? SFD_BYTE : PREAMBLE_BYTE;
            end
            ST_HEADER: begin
                gmii_txd_o <= hdr_q.bytes[6'(HEADER_BYTES - 1) - byte_cnt_q[5:0]];
            end
            ST_PAYLOAD: begin
                gmii_txd_o <= s_valid_i ? s_beat_i.data : 8'h00;
            end
            default: begin
                gmii_txd_o <= 8'h00;
            end
        endcase
    end

    // The source must flag last exactly on the byte that completes the latched length.
    a_last_at_length: assert property (@(posedge clk_i) disable iff (reset_i)
        (gmii_tx_en_o && s_valid_i && s_ready_o)
            |-> (s_beat_i.last == (byte_cnt_q == len_q - cnt_t'(1))));

endmodule

`default_nettype wire

// ==== logic/udp_frame_rx.sv ====
`timescale 1ns/1ps
`default_nettype none

module udp_frame_rx #(
    parameter logic CHECK_DESTINATION = 1'b1
) (
    input  logic                       clk_i,
    input  logic                       reset_i,

    input  logic                       gmii_rx_dv_i,
    input  logic [7:0]                 gmii_rxd_i,

    input  logic [47:0]                fpga_mac_i,
    input  logic [31:0]                fpga_ip_i,
    input  logic [15:0]                fpga_port_i,

    output logic                       rx_wr_o,
    output udp_link_pkg::stream_beat_t rx_beat_o
);

    import udp_link_pkg::*;

    typedef logic [AXIS_USER_WIDTH-1:0] cnt_t;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_HEADER,
        ST_PAYLOAD,
        ST_DROP
    } rx_state_e;

    rx_state_e     state_q;
    cnt_t          byte_cnt_q;
    cnt_t          pay_len_q;
    frame_header_u hdr_q;
    frame_header_u hdr_d;
    logic [15:0]   pay_len_w;
    logic          hdr_ok;
    logic          pay_last;

    // ~~~~~~~~~~~~~~~~~~~~
    // Header decode.
    // Bytes shift in at the bottom, so the first byte ends up at the top of the struct.
    always_comb begin
        hdr_d.bytes = {hdr_q.bytes[HEADER_BYTES-2:0], gmii_rxd_i};
        pay_len_w   = hdr_d.fields.udp_len - 16'(UDP_HDR_BYTES);

        hdr_ok = (hdr_d.fields.ethertype == ETHERTYPE_IPV4)
              && (hdr_d.fields.ip_protocol == IP_PROTO_UDP)
              && (hdr_d.fields.udp_len > 16'(UDP_HDR_BYTES))
              && (pay_len_w[15:AXIS_USER_WIDTH] == '0);

        if (CHECK_DESTINATION) begin
            hdr_ok = hdr_ok
                  && (hdr_d.fields.dst_mac == fpga_mac_i)
                  && (hdr_d.fields.dst_ip == fpga_ip_i)
                  && (hdr_d.fields.dst_port == fpga_port_i);
        end
    end

    assign pay_last = (byte_cnt_q == pay_len_q - cnt_t'(1));

    // ~~~~~~~~~~~~~~~~~~~~
    // Frame tracking.
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q    <= ST_IDLE;
            byte_cnt_q <= '0;
            rx_wr_o    <= 1'b0;
        end else begin
            rx_wr_o <= 1'b0;
            case (state_q)
                ST_IDLE: begin
                    if (gmii_rx_dv_i && gmii_rxd_i == SFD_BYTE) begin
                        state_q    <= ST_HEADER;
                        byte_cnt_q <= '0;
                    end
                end
                ST_HEADER: begin
                    if (!gmii_rx_dv_i) begin
                        state_q <= ST_IDLE;
                    end else if (byte_cnt_q == cnt_t'(HEADER_BYTES - 1)) begin
                        state_q    <= hdr_ok ? ST_PAYLOAD : ST_DROP;
                        byte_cnt_q <= '0;
                    end else begin
                        byte_cnt_q <= byte_cnt_q + cnt_t'(1);
                    end
                end
                ST_PAYLOAD: begin
                    if (!gmii_rx_dv_i) begin
                        state_q <= ST_IDLE;
                    end else begin
                        rx_wr_o <= 1'b1;
                        if (pay_last) begin
                            state_q <= ST_DROP;
                        end else begin
                            byte_cnt_q <= byte_cnt_q + cnt_t'(1);
                        end
                    end
                end
                default: begin
                    // Wait for the end of the frame.
                    if (!gmii_rx_dv_i) begin
                        state_q <= ST_IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (state_q == ST_HEADER && gmii_rx_dv_i) begin
            hdr_q <= hdr_d;
            if (byte_cnt_q == cnt_t'(HEADER_BYTES - 1)) begin
                pay_len_q <= pay_len_w[AXIS_USER_WIDTH-1:0];
            end
        end
        if (state_q == ST_PAYLOAD && gmii_rx_dv_i) begin
            rx_beat_o.data <= gmii_rxd_i;
            rx_beat_o.last <= pay_last;
            rx_beat_o.user <= pay_len_q;
        end
    end

    // Every write comes from a byte seen with dv high, a whole header or more after the SFD.
    a_wr_inside_frame: assert property (@(posedge clk_i) disable iff (reset_i)
        rx_wr_o |-> $past(gmii_rx_dv_i) && $past(gmii_rx_dv_i, HEADER_BYTES + 2));

endmodule

`default_nettype wire

// ==== logic/rx_stream_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module rx_stream_fifo #(
    parameter int FIFO_DEPTH = 2048
) (
    input  logic                       clk_i,
    input  logic                       reset_i,

    input  logic                       wr_i,
    input  udp_link_pkg::stream_beat_t wr_beat_i,

    output logic                       m_valid_o,
    output udp_link_pkg::stream_beat_t m_beat_o,
    input  logic                       m_ready_i,

    output logic                       overflow_o
);

    import udp_link_pkg::*;

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    typedef logic [PTR_W-1:0] ptr_t;
    typedef logic [CNT_W-1:0] count_t;

    stream_beat_t mem [FIFO_DEPTH];

    ptr_t   wr_ptr_q;
    ptr_t   rd_ptr_q;
    count_t count_q;
    logic   full;
    logic   push;
    logic   load;

    assign full = (count_q == count_t'(FIFO_DEPTH));
    assign push = wr_i && !full;
    // The output register refills whenever it is empty or being drained.
    assign load = (count_q != '0) && (!m_valid_o || m_ready_i);

    always_ff @(posedge clk_i) begin
        if (push) begin
            mem[wr_ptr_q] <= wr_beat_i;
        end
        if (load) begin
            m_beat_o <= mem[rd_ptr_q];
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            wr_ptr_q   <= '0;
            rd_ptr_q   <= '0;
            count_q    <= '0;
            m_valid_o  <= 1'b0;
            overflow_o <= 1'b0;
        end else begin
            overflow_o <= wr_i && full;
            if (push) begin
                wr_ptr_q <= (wr_ptr_q == ptr_t'(FIFO_DEPTH - 1)) ? '0 : wr_ptr_q + ptr_t'(1);
            end
            if (load) begin
                rd_ptr_q  <= (rd_ptr_q == ptr_t'(FIFO_DEPTH - 1)) ? '0 : rd_ptr_q + ptr_t'(1);
                m_valid_o <= 1'b1;
            end else if (m_ready_i) begin
                m_valid_o <= 1'b0;
            end
            count_q <= count_q + count_t'(push) - count_t'(load);
        end
    end

    a_count_bounded: assert property (@(posedge clk_i) disable iff (reset_i)
        count_q <= count_t'(FIFO_DEPTH));

endmodule

`default_nettype wire

// ==== logic/udp_gmii_link.sv ====
`timescale 1ns/1ps
`default_nettype none

module udp_gmii_link #(
    parameter logic [15:0] HEADER_CHECKSUM   = 16'h65b3,
    parameter logic        CHECK_DESTINATION = 1'b1,
    parameter int          FIFO_DEPTH        = 2048
) (
    input  logic                       clk_i,
    input  logic                       reset_i,

    input  logic [47:0]                fpga_mac_i,
    input  logic [31:0]                fpga_ip_i,
    input  logic [15:0]                fpga_port_i,
    input  logic [47:0]                host_mac_i,
    input  logic [31:0]                host_ip_i,
    input  logic [15:0]                host_port_i,

    input  logic                       s_valid_i,
    input  udp_link_pkg::stream_beat_t s_beat_i,
    output logic                       s_ready_o,

    output logic                       gmii_tx_en_o,
    output logic [7:0]                 gmii_txd_o,
    input  logic                       gmii_rx_dv_i,
    input  logic [7:0]                 gmii_rxd_i,

    output logic                       m_valid_o,
    output udp_link_pkg::stream_beat_t m_beat_o,
    input  logic                       m_ready_i,

    output logic                       rx_overflow_o
);

    import udp_link_pkg::*;

    logic         rx_wr;
    stream_beat_t rx_beat;

    udp_frame_tx #(
        .HEADER_CHECKSUM(HEADER_CHECKSUM)
    ) i_udp_frame_tx (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .s_valid_i   (s_valid_i),
        .s_beat_i    (s_beat_i),
        .s_ready_o   (s_ready_o),
        .fpga_mac_i  (fpga_mac_i),
        .fpga_ip_i   (fpga_ip_i),
        .fpga_port_i (fpga_port_i),
        .host_mac_i  (host_mac_i),
        .host_ip_i   (host_ip_i),
        .host_port_i (host_port_i),
        .gmii_tx_en_o(gmii_tx_en_o),
        .gmii_txd_o  (gmii_txd_o)
    );

    udp_frame_rx #(
        .CHECK_DESTINATION(CHECK_DESTINATION)
    ) i_udp_frame_rx (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .gmii_rx_dv_i(gmii_rx_dv_i),
        .gmii_rxd_i  (gmii_rxd_i),
        .fpga_mac_i  (fpga_mac_i),
        .fpga_ip_i   (fpga_ip_i),
        .fpga_port_i (fpga_port_i),
        .rx_wr_o     (rx_wr),
        .rx_beat_o   (rx_beat)
    );

    rx_stream_fifo #(
        .FIFO_DEPTH(FIFO_DEPTH)
    ) i_rx_stream_fifo (
        .clk_i     (clk_i),
        .reset_i   (reset_i),
        .wr_i      (rx_wr),
        .wr_beat_i (rx_beat),
        .m_valid_o (m_valid_o),
        .m_beat_o  (m_beat_o),
        .m_ready_i (m_ready_i),
        .overflow_o(rx_overflow_o)
    );

endmodule

`default_nettype wire

// ==== verification/tb_clock_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD_NS    = 10,
    parameter int RESET_CYCLES = 3
) (
    output logic clk_o,
    output logic reset_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    // Reset drops just after an edge, in step with the rest of the stimulus.
    initial begin
        reset_o = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_o);
        #1;
        reset_o = 1'b0;
    end

endmodule

`default_nettype wire

// ==== verification/udp_gmii_link_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module udp_gmii_link_tb;

    import udp_link_pkg::*;

    localparam int          NUM_FRAMES     = 12;
    localparam int          MAX_LEN        = 64;
    localparam int          HDR_END        = 8 + 42;
    localparam int          DST_PORT_POS   = 8 + 36;
    localparam int          TIMEOUT_CYCLES = NUM_FRAMES * (8 + 42 + MAX_LEN + 12) * 4 + 1000;
    localparam logic [15:0] HDR_CSUM       = 16'hb861;
    localparam logic [47:0] NODE_MAC       = 48'h02_00_00_12_34_56;
    localparam logic [31:0] NODE_IP        = 32'hc0a8_0102;
    localparam logic [15:0] NODE_PORT      = 16'd5000;

    logic         clk_i;
    logic         reset_i;
    logic [47:0]  fpga_mac_i;
    logic [31:0]  fpga_ip_i;
    logic [15:0]  fpga_port_i;
    logic [47:0]  host_mac_i;
    logic [31:0]  host_ip_i;
    logic [15:0]  host_port_i;
    logic         s_valid_i;
    stream_beat_t s_beat_i;
    logic         s_ready_o;
    logic         gmii_tx_en_o;
    logic [7:0]   gmii_txd_o;
    logic         gmii_rx_dv_i = 1'b0;
    logic [7:0]   gmii_rxd_i   = 8'h00;
    logic         m_valid_o;
    stream_beat_t m_beat_o;
    logic         m_ready_i    = 1'b0;
    logic         rx_overflow_o;

    logic [31:0]  lfsr_state = 32'h98ad;
    int           frame_len [NUM_FRAMES];
    logic         frame_corrupt [NUM_FRAMES];
    logic [7:0]   payload [NUM_FRAMES][MAX_LEN];
    stream_beat_t exp_beats [1024];
    int           exp_wr = 0;
    int           exp_rd = 0;
    logic         out_take = 1'b0;
    int           errors = 0;
    int           dropped = 0;
    int           cycles = 0;

    // Bookkeeping of the frame currently on the transmit wire.
    logic         offered = 1'b0;
    int           cur_len = 0;
    logic         cur_corrupt = 1'b0;
    int           wire_len = 0;
    logic         wire_corrupt = 1'b0;
    int           tx_run = 0;
    int           tx_pos = 0;
    int           idle_run = 12;
    int           gap_before = 12;
    int           ready_run = 0;
    int           ended_run = 0;
    int           ended_ready = 0;
    logic         frame_start = 1'b0;
    logic         frame_end = 1'b0;
    logic [7:0]   exp_txd = 8'h00;
    logic         loop_dv = 1'b0;
    logic [7:0]   loop_rxd = 8'h00;

    tb_clock_gen i_clock_gen (
        .clk_o  (clk_i),
        .reset_o(reset_i)
    );

    udp_gmii_link #(
        .HEADER_CHECKSUM  (HDR_CSUM),
        .CHECK_DESTINATION(1'b1),
        .FIFO_DEPTH       (2048)
    ) DUT (.*);

    // ~~~~~~~~~~~~~~~~~~~~
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_state[0]};
            lfsr_state = lfsr_step(lfsr_state);
        end
        return v;
    endfunction

    // Wire bytes of a frame: preamble, SFD, then the header in network order.
    function automatic logic [7:0] expected_tx_byte(input int pos, input int len);
        logic [335:0] hdr;
        hdr = {NODE_MAC, NODE_MAC, 16'h0800, 8'h45, 8'h00, 16'(28 + len), 16'h0000,
               16'h4000, 8'd64, 8'd17, HDR_CSUM, NODE_IP, NODE_IP, NODE_PORT,
               NODE_PORT, 16'(8 + len), 16'h0000};
        if (pos < 7) return 8'h55;
        if (pos == 7) return 8'hd5;
        if (pos < HDR_END) return hdr[335 - 8 * (pos - 8) -: 8];
        return 8'h00;
    endfunction

    function automatic stream_beat_t make_beat(input int f, input int k);
        stream_beat_t b;
        b.data = payload[f][k];
        b.last = (k == frame_len[f] - 1);
        b.user = AXIS_USER_WIDTH'(frame_len[f]);
        return b;
    endfunction

    task automatic flag_error(input string what);
        errors++;
        $display("ERROR at %0t: %s", $time, what);
    endtask

    task automatic print_counts();
        $display("frames %0d, dropped %0d, beats checked %0d of %0d, errors %0d",
                 NUM_FRAMES, dropped, exp_rd, exp_wr, errors);
    endtask

    task automatic send_frame(input int f);
        int   k;
        logic took;
        cur_len     = frame_len[f];
        cur_corrupt = frame_corrupt[f];
        offered     = 1'b1;
        k           = 0;
        s_valid_i   = 1'b1;
        s_beat_i    = make_beat(f, 0);
        while (k < frame_len[f]) begin
            took = s_ready_o;
            @(posedge clk_i);
            #1;
            if (took) begin
                if (!frame_corrupt[f]) begin
                    exp_beats[exp_wr] = s_beat_i;
                    exp_wr++;
                end
                k++;
                if (k < frame_len[f]) begin
                    s_beat_i = make_beat(f, k);
                end
            end
        end
        s_valid_i = 1'b0;
    endtask

    // ~~~~~~~~~~~~~~~~~~~~
    // Loopback with a one cycle delay, plus tracking of frame position and spacing.
    always @(posedge clk_i) begin
        #1;
        frame_start = 1'b0;
        frame_end   = 1'b0;
        if (gmii_tx_en_o) begin
            if (tx_run == 0) begin
                frame_start  = 1'b1;
                wire_len     = cur_len;
                wire_corrupt = cur_corrupt;
                gap_before   = idle_run;
            end
            tx_pos = tx_run;
            tx_run++;
            idle_run = 0;
        end else begin
            if (tx_run != 0) begin
                frame_end   = 1'b1;
                ended_run   = tx_run;
                ended_ready = ready_run;
                ready_run   = 0;
            end
            tx_run = 0;
            idle_run++;
        end
        if (s_ready_o) ready_run++;
        exp_txd      = expected_tx_byte(tx_pos, wire_len);
        gmii_rx_dv_i = loop_dv;
        gmii_rxd_i   = loop_rxd;
        loop_dv      = gmii_tx_en_o;
        if (wire_corrupt && gmii_tx_en_o && tx_pos == DST_PORT_POS) begin
            loop_rxd = gmii_txd_o ^ 8'h5a;
        end else begin
            loop_rxd = gmii_txd_o;
        end
    end

    always @(posedge clk_i) begin
        logic [31:0] r;
        #1;
        if (out_take) exp_rd++;
        r         = take_bits(1);
        m_ready_i = r[0];
        out_take  = m_valid_o && m_ready_i;
    end

    // ~~~~~~~~~~~~~~~~~~~~
    a_quiet_after_reset: assert property (@(posedge clk_i) disable iff (reset_i)
        !offered |-> !gmii_tx_en_o && !s_ready_o && !m_valid_o && !rx_overflow_o)
        else flag_error("output active before any payload was offered");

    a_preamble_header: assert property (@(posedge clk_i) disable iff (reset_i)
        (gmii_tx_en_o && tx_pos < HDR_END) |-> gmii_txd_o == exp_txd)
        else flag_error($sformatf("tx byte %0d is %h, expected %h", tx_pos, gmii_txd_o, exp_txd));

    a_frame_length: assert property (@(posedge clk_i) disable iff (reset_i)
        frame_end |-> ended_run == HDR_END + wire_len)
        else flag_error($sformatf("tx_en high %0d cycles for length %0d", ended_run, wire_len));

    a_ready_count: assert property (@(posedge clk_i) disable iff (reset_i)
        frame_end |-> ended_ready == wire_len)
        else flag_error($sformatf("s_ready high %0d times for length %0d", ended_ready, wire_len));

    a_frame_gap: assert property (@(posedge clk_i) disable iff (reset_i)
        frame_start |-> gap_before >= 12)
        else flag_error($sformatf("interframe gap of only %0d cycles", gap_before));

    a_no_overflow: assert property (@(posedge clk_i) disable iff (reset_i)
        !rx_overflow_o)
        else flag_error("receive FIFO overflow");

    a_rx_beat: assert property (@(posedge clk_i) disable iff (reset_i)
        (m_valid_o && m_ready_i) |-> (exp_rd < exp_wr && m_beat_o == exp_beats[exp_rd]))
        else flag_error($sformatf("output beat %0d is %h, expected %h", exp_rd, m_beat_o,
                                  exp_beats[exp_rd]));

    // ~~~~~~~~~~~~~~~~~~~~
    initial begin
        logic [31:0] r;
        s_valid_i   = 1'b0;
        s_beat_i    = '0;
        fpga_mac_i  = NODE_MAC;
        fpga_ip_i   = NODE_IP;
        fpga_port_i = NODE_PORT;
        host_mac_i  = NODE_MAC;
        host_ip_i   = NODE_IP;
        host_port_i = NODE_PORT;

        for (int f = 0; f < NUM_FRAMES; f++) begin
            r = take_bits(6);
            frame_len[f] = int'(r[5:0]) + 1;
            r = take_bits(2);
            // Frame 4 always gets a bad port so the drop path is exercised.
            frame_corrupt[f] = (r[1:0] == 2'b00) || (f == 4);
            if (frame_corrupt[f]) dropped++;
            for (int k = 0; k < frame_len[f]; k++) begin
                r = take_bits(8);
                payload[f][k] = r[7:0];
            end
        end

        while (reset_i) @(posedge clk_i);
        @(posedge clk_i);
        #1;
        for (int f = 0; f < NUM_FRAMES; f++) begin
            send_frame(f);
        end

        while (gmii_tx_en_o || gmii_rx_dv_i) @(posedge clk_i);
        while (exp_rd < exp_wr || m_valid_o) @(posedge clk_i);
        // The FIFO read path is two cycles deep, so stray beats would show by now.
        repeat (4) @(posedge clk_i);

        print_counts();
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    initial begin
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk_i);
            cycles++;
        end
        $display("Run timed out after %0d cycles before all frames were checked", cycles);
        print_counts();
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
logic/udp_link_pkg.sv
logic/udp_frame_tx.sv
logic/udp_frame_rx.sv
logic/rx_stream_fifo.sv
logic/udp_gmii_link.sv
verification/tb_clock_gen.sv
verification/udp_gmii_link_tb.sv

// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing --assert
TOP       := udp_gmii_link_tb
FILELIST  := verilog.f

SOURCES   := $(shell grep -v '^+' $(FILELIST))
BIN       := obj_dir/V$(TOP)
PASS_MSG  := *** TEST PASSED ***

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf obj_dir
